// File: common/webp_fetch_defines.svh
// WebP fetch stage constants
// Bus widths, burst lengths and the macroblock byte stride
`ifndef WEBP_FETCH_DEFINES_SVH
`define WEBP_FETCH_DEFINES_SVH

// AXI4 read port
`define WF_ADDR_WIDTH     64
`define WF_DATA_WIDTH     256
`define WF_ID_WIDTH       2
`define WF_USER_WIDTH     8
`define WF_CTX_WIDTH      32

// Frame size and encoder parameter fields
`define WF_DIM_WIDTH      32
`define WF_SCALAR_WIDTH   32
`define WF_COEF_WIDTH     128

// Burst shapes
`define WF_DQM_BEATS      6
`define WF_DQM_IDX_WIDTH  3
`define WF_MB_BEATS       3
`define WF_BEAT_BYTES     (`WF_DATA_WIDTH / 8)
`define WF_MB_BYTES       (`WF_MB_BEATS * `WF_BEAT_BYTES)

`endif

// File: common/webp_fetch_pkg.sv
// WebP fetch stage types
// Read master states and the steering tag of each R beat
package webp_fetch_pkg;

    // Read master sequence
    typedef enum logic [2:0] {
        IDLE,
        DQM_REQ,
        DQM_DATA,
        MB_REQ,
        MB_DATA,
        DONE
    } rd_state_t;

    // Where an accepted R beat goes
    typedef enum logic [1:0] {
        NONE,
        DQM,
        MB
    } beat_kind_t;

endpackage

// File: rtl/axi_master_rd.sv
// AXI4 read master of the WebP fetch stage
// Reads the DQM block, then one burst per macroblock, and steers R beats
`timescale 1ns/100ps
`include "webp_fetch_defines.svh"

module axi_master_rd (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`WF_CTX_WIDTH-1:0]      snap_context,
    input  logic                          start_pulse,
    input  logic [`WF_ADDR_WIDTH-1:0]     dqm_address,
    input  logic                          y0_fifo_full,
    input  logic                          y1_fifo_full,
    input  logic                          uv_fifo_full,
    input  logic [`WF_ADDR_WIDTH-1:0]     mb_addr,
    input  logic                          mb_last,
    // AR channel
    output logic [`WF_ID_WIDTH-1:0]       arid,
    output logic [`WF_ADDR_WIDTH-1:0]     araddr,
    output logic [7:0]                    arlen,
    output logic [2:0]                    arsize,
    output logic [1:0]                    arburst,
    output logic [`WF_USER_WIDTH-1:0]     aruser,
    output logic [3:0]                    arcache,
    output logic [1:0]                    arlock,
    output logic [2:0]                    arprot,
    output logic [3:0]                    arqos,
    output logic [3:0]                    arregion,
    output logic                          arvalid,
    input  logic                          arready,
    // R channel
    input  logic [`WF_ID_WIDTH-1:0]       rid,
    input  logic [`WF_DATA_WIDTH-1:0]     rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rlast,
    input  logic                          rvalid,
    output logic                          rready,
    // Toward the address generator and the beat consumers
    output logic                          mb_start,
    output logic                          mb_step,
    output webp_fetch_pkg::beat_kind_t    beat_kind,
    output logic [`WF_DATA_WIDTH-1:0]     beat_data,
    output logic                          beat_valid,
    output logic                          beat_last,
    output logic [`WF_DQM_IDX_WIDTH-1:0]  dqm_index,
    output logic                          done_pulse,
    output logic                          rd_error
);

    import webp_fetch_pkg::*;

    localparam int unsigned BEAT_SIZE = $clog2(`WF_DATA_WIDTH / 8);

    rd_state_t               state;
    rd_state_t               state_nxt;
    logic                    start_in;
    logic                    any_full;
    logic                    ar_hs;
    logic                    ar_load;
    logic [`WF_ID_WIDTH-1:0] issued_id;

    // ------------------------------------------------------------------------
    // Fixed AR attributes
    // ------------------------------------------------------------------------
    assign arsize   = 3'(BEAT_SIZE);
    assign arburst  = 2'd1;   // INCR
    assign arcache  = 4'd3;   // normal non-cacheable, bufferable
    assign arlock   = 2'd0;
    assign arprot   = 3'd0;
    assign arqos    = 4'd0;
    assign arregion = 4'd0;
    assign aruser   = snap_context[`WF_USER_WIDTH-1:0];

    assign start_in = (state == IDLE) && start_pulse;
    assign any_full = y0_fifo_full || y1_fifo_full || uv_fifo_full;
    assign ar_hs    = arvalid && arready;
    // Macroblock requests only start with room in all three FIFOs
    assign ar_load  = !arvalid &&
                      ((state == DQM_REQ) || ((state == MB_REQ) && !any_full));

    // R channel is never stalled inside a data state
    assign rready     = (state == DQM_DATA) || (state == MB_DATA);
    assign beat_valid = rvalid && rready;
    assign beat_data  = rdata;
    assign beat_last  = rlast;

    assign mb_start   = start_in;
    assign mb_step    = beat_valid && rlast && (state == MB_DATA);
    assign done_pulse = (state == DONE);

    always_comb begin
        case (state)
            DQM_DATA: beat_kind = DQM;
            MB_DATA:  beat_kind = MB;
            default:  beat_kind = NONE;
        endcase
    end

    // ------------------------------------------------------------------------
    // Sequencing FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (start_pulse) state_nxt = DQM_REQ;
            DQM_REQ:  if (ar_hs) state_nxt = DQM_DATA;
            DQM_DATA: if (beat_valid && rlast) state_nxt = MB_REQ;
            MB_REQ:   if (ar_hs) state_nxt = MB_DATA;
            MB_DATA: begin
                if (mb_step) begin
                    state_nxt = mb_last ? DONE : MB_REQ;
                end
            end
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            arvalid   <= 1'b0;
            arid      <= '0;
            issued_id <= '0;
            rd_error  <= 1'b0;
            dqm_index <= '0;
        end else begin
            state <= state_nxt;

            if (ar_hs) begin
                arvalid <= 1'b0;
            end else if (ar_load) begin
                arvalid <= 1'b1;
            end

            // Burst ID restarts with every frame
            if (start_in) begin
                arid <= '0;
            end else if (ar_hs) begin
                arid      <= arid + 1'b1;
                issued_id <= arid;
            end

            // Bad beats are still consumed and only flagged
            if (start_in) begin
                rd_error <= 1'b0;
            end else if (beat_valid && ((rresp != 2'b00) || (rid != issued_id))) begin
                rd_error <= 1'b1;
            end

            if (state != DQM_DATA) begin
                dqm_index <= '0;
            end else if (beat_valid) begin
                dqm_index <= dqm_index + 1'b1;
            end
        end
    end

    // Address and length of the next request
    always_ff @(posedge clk) begin
        if (ar_load) begin
            if (state == DQM_REQ) begin
                araddr <= dqm_address;
                arlen  <= 8'(`WF_DQM_BEATS - 1);
            end else begin
                araddr <= mb_addr;
                arlen  <= 8'(`WF_MB_BEATS - 1);
            end
        end
    end

endmodule

// File: rtl/dqm_unpack.sv
// DQM parameter unpacker
// Loads the six DQM beats into the encoder's lambda, quantizer and sharpen registers
`timescale 1ns/100ps
`include "webp_fetch_defines.svh"

module dqm_unpack (
    input  logic                          clk,
    input  logic                          rst_n,
    input  webp_fetch_pkg::beat_kind_t    beat_kind,
    input  logic [`WF_DATA_WIDTH-1:0]     beat_data,
    input  logic                          beat_valid,
    input  logic                          beat_last,
    input  logic [`WF_DQM_IDX_WIDTH-1:0]  dqm_index,
    output logic [`WF_SCALAR_WIDTH-1:0]   lambda_i16,
    output logic [`WF_SCALAR_WIDTH-1:0]   lambda_i4,
    output logic [`WF_SCALAR_WIDTH-1:0]   lambda_uv,
    output logic [`WF_SCALAR_WIDTH-1:0]   tlambda,
    output logic [`WF_SCALAR_WIDTH-1:0]   lambda_mode,
    output logic [`WF_SCALAR_WIDTH-1:0]   min_disto,
    output logic [`WF_SCALAR_WIDTH-1:0]   max_edge,
    output logic [`WF_COEF_WIDTH-1:0]     y1_q,
    output logic [`WF_COEF_WIDTH-1:0]     y1_iq,
    output logic [`WF_COEF_WIDTH-1:0]     y1_sharpen,
    output logic [`WF_COEF_WIDTH-1:0]     y2_q,
    output logic [`WF_COEF_WIDTH-1:0]     y2_iq,
    output logic [`WF_COEF_WIDTH-1:0]     y2_sharpen,
    output logic [`WF_COEF_WIDTH-1:0]     uv_q,
    output logic [`WF_COEF_WIDTH-1:0]     uv_iq,
    output logic [`WF_COEF_WIDTH-1:0]     uv_sharpen,
    output logic                          reload
);

    import webp_fetch_pkg::*;

    localparam int S = `WF_SCALAR_WIDTH;
    localparam int C = `WF_COEF_WIDTH;

    logic dqm_beat;

    assign dqm_beat = beat_valid && (beat_kind == DQM);

    // Encoder picks up the new set one cycle after the final beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reload <= 1'b0;
        end else begin
            reload <= dqm_beat && beat_last;
        end
    end

    // Beat 0 holds scalars, beats 1..3 q/iq pairs, beats 4..5 sharpen
    always_ff @(posedge clk) begin
        if (dqm_beat) begin
            case (dqm_index)
                3'd0: begin
                    lambda_i16  <= beat_data[0*S +: S];
                    lambda_i4   <= beat_data[1*S +: S];
                    lambda_uv   <= beat_data[2*S +: S];
                    tlambda     <= beat_data[3*S +: S];
                    lambda_mode <= beat_data[4*S +: S];
                    min_disto   <= beat_data[5*S +: S];
                    max_edge    <= beat_data[6*S +: S];
                end
                3'd1: begin
                    y1_q  <= beat_data[0 +: C];
                    y1_iq <= beat_data[C +: C];
                end
                3'd2: begin
                    y2_q  <= beat_data[0 +: C];
                    y2_iq <= beat_data[C +: C];
                end
                3'd3: begin
                    uv_q  <= beat_data[0 +: C];
                    uv_iq <= beat_data[C +: C];
                end
                3'd4: begin
                    y1_sharpen <= beat_data[0 +: C];
                    y2_sharpen <= beat_data[C +: C];
                end
                // Upper half of beat 5 is spare
                3'd5: uv_sharpen <= beat_data[0 +: C];
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/mb_addr_gen.sv
// Macroblock address generator
// Walks the frame in raster order and tracks the source address of each macroblock
`timescale 1ns/100ps
`include "webp_fetch_defines.svh"

module mb_addr_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mb_start,
    input  logic                       mb_step,
    input  logic [`WF_ADDR_WIDTH-1:0]  source_address,
    input  logic [`WF_DIM_WIDTH-1:0]   mb_w,
    input  logic [`WF_DIM_WIDTH-1:0]   mb_h,
    output logic [`WF_ADDR_WIDTH-1:0]  mb_addr,
    output logic                       mb_last
);

    logic [`WF_DIM_WIDTH-1:0] col;
    logic [`WF_DIM_WIDTH-1:0] row;
    logic                     row_end;

    assign row_end = (col == mb_w - 1'b1);
    // Points at the final macroblock of the frame
    assign mb_last = row_end && (row == mb_h - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col     <= '0;
            row     <= '0;
            mb_addr <= '0;
        end else if (mb_start) begin
            col     <= '0;
            row     <= '0;
            mb_addr <= source_address;
        end else if (mb_step) begin
            if (row_end) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
            // Macroblocks sit back to back in memory
            mb_addr <= mb_addr + `WF_ADDR_WIDTH'(`WF_MB_BYTES);
        end
    end

endmodule

// File: rtl/yuv_beat_pack.sv
// Macroblock beat packer
// Collects Y0 and Y1 beats, then writes Y0, Y1 and UV FIFOs together on the UV beat
`timescale 1ns/100ps
`include "webp_fetch_defines.svh"

module yuv_beat_pack (
    input  logic                          clk,
    input  logic                          rst_n,
    input  webp_fetch_pkg::beat_kind_t    beat_kind,
    input  logic [`WF_DATA_WIDTH-1:0]     beat_data,
    input  logic                          beat_valid,
    input  logic                          beat_last,
    output logic [`WF_DATA_WIDTH-1:0]     y0_fifo_din,
    output logic [`WF_DATA_WIDTH-1:0]     y1_fifo_din,
    output logic [`WF_DATA_WIDTH-1:0]     uv_fifo_din,
    output logic                          fifo_wr
);

    import webp_fetch_pkg::*;

    logic       mb_beat;
    logic [1:0] beat_cnt;

    assign mb_beat = beat_valid && (beat_kind == MB);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= 2'd0;
            fifo_wr  <= 1'b0;
        end else begin
            fifo_wr <= mb_beat && beat_last;
            if (mb_beat) begin
                beat_cnt <= beat_last ? 2'd0 : beat_cnt + 2'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Beat holding registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (mb_beat) begin
            if (beat_last) begin
                uv_fifo_din <= beat_data;
            end else begin
                case (beat_cnt)
                    2'd0:    y0_fifo_din <= beat_data;
                    2'd1:    y1_fifo_din <= beat_data;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: rtl/webp_fetch_top.sv
// WebP encoder input fetch stage
// Read master, DQM unpacker, macroblock addressing and beat packer on one AXI4 read port
`timescale 1ns/100ps
`include "webp_fetch_defines.svh"

module webp_fetch_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`WF_CTX_WIDTH-1:0]      snap_context,
    // Frame control
    input  logic                          start_pulse,
    input  logic [`WF_ADDR_WIDTH-1:0]     source_address,
    input  logic [`WF_ADDR_WIDTH-1:0]     dqm_address,
    input  logic [`WF_DIM_WIDTH-1:0]      mb_w,
    input  logic [`WF_DIM_WIDTH-1:0]      mb_h,
    // AXI4 AR channel
    output logic [`WF_ID_WIDTH-1:0]       arid,
    output logic [`WF_ADDR_WIDTH-1:0]     araddr,
    output logic [7:0]                    arlen,
    output logic [2:0]                    arsize,
    output logic [1:0]                    arburst,
    output logic [`WF_USER_WIDTH-1:0]     aruser,
    output logic [3:0]                    arcache,
    output logic [1:0]                    arlock,
    output logic [2:0]                    arprot,
    output logic [3:0]                    arqos,
    output logic [3:0]                    arregion,
    output logic                          arvalid,
    input  logic                          arready,
    // AXI4 R channel
    input  logic [`WF_ID_WIDTH-1:0]       rid,
    input  logic [`WF_DATA_WIDTH-1:0]     rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rlast,
    input  logic                          rvalid,
    output logic                          rready,
    // Encoder parameters
    output logic [`WF_SCALAR_WIDTH-1:0]   lambda_i16,
    output logic [`WF_SCALAR_WIDTH-1:0]   lambda_i4,
    output logic [`WF_SCALAR_WIDTH-1:0]   lambda_uv,
    output logic [`WF_SCALAR_WIDTH-1:0]   tlambda,
    output logic [`WF_SCALAR_WIDTH-1:0]   lambda_mode,
    output logic [`WF_SCALAR_WIDTH-1:0]   min_disto,
    output logic [`WF_SCALAR_WIDTH-1:0]   max_edge,
    output logic [`WF_COEF_WIDTH-1:0]     y1_q,
    output logic [`WF_COEF_WIDTH-1:0]     y1_iq,
    output logic [`WF_COEF_WIDTH-1:0]     y1_sharpen,
    output logic [`WF_COEF_WIDTH-1:0]     y2_q,
    output logic [`WF_COEF_WIDTH-1:0]     y2_iq,
    output logic [`WF_COEF_WIDTH-1:0]     y2_sharpen,
    output logic [`WF_COEF_WIDTH-1:0]     uv_q,
    output logic [`WF_COEF_WIDTH-1:0]     uv_iq,
    output logic [`WF_COEF_WIDTH-1:0]     uv_sharpen,
    output logic                          reload,
    // Pixel FIFOs
    input  logic                          y0_fifo_full,
    input  logic                          y1_fifo_full,
    input  logic                          uv_fifo_full,
    output logic [`WF_DATA_WIDTH-1:0]     y0_fifo_din,
    output logic [`WF_DATA_WIDTH-1:0]     y1_fifo_din,
    output logic [`WF_DATA_WIDTH-1:0]     uv_fifo_din,
    output logic                          fifo_wr,
    // Status
    output logic                          done_pulse,
    output logic                          rd_error
);

    import webp_fetch_pkg::*;

    // Beat steering from the master
    beat_kind_t                   beat_kind;
    logic [`WF_DATA_WIDTH-1:0]    beat_data;
    logic                         beat_valid;
    logic                         beat_last;
    logic [`WF_DQM_IDX_WIDTH-1:0] dqm_index;

    // Macroblock walk
    logic                         mb_start;
    logic                         mb_step;
    logic [`WF_ADDR_WIDTH-1:0]    mb_addr;
    logic                         mb_last;

    axi_master_rd i_axi_master_rd (.*);

    dqm_unpack i_dqm_unpack (.*);

    mb_addr_gen i_mb_addr_gen (.*);

    yuv_beat_pack i_yuv_beat_pack (.*);

endmodule

// File: bench/webp_fetch_properties.sv
// Protocol properties of the WebP fetch stage
// AR channel stability, FIFO back-pressure and single-cycle pulses
`timescale 1ns/100ps
`include "webp_fetch_defines.svh"

module webp_fetch_properties (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       arvalid,
    input logic                       arready,
    input logic [`WF_ID_WIDTH-1:0]    arid,
    input logic [`WF_ADDR_WIDTH-1:0]  araddr,
    input logic [7:0]                 arlen,
    input logic [2:0]                 arsize,
    input logic [1:0]                 arburst,
    input logic [3:0]                 arcache,
    input logic                       y0_fifo_full,
    input logic                       y1_fifo_full,
    input logic                       uv_fifo_full,
    input logic                       reload,
    input logic                       fifo_wr,
    input logic                       done_pulse
);

    int unsigned assert_errors = 0;
    logic        any_full;

    assign any_full = y0_fifo_full || y1_fifo_full || uv_fifo_full;

    // AR payload held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable({arid, araddr, arlen}))
        else begin
            $error("AR request changed before arready");
            assert_errors++;
        end

    ar_fixed: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> arsize == 3'($clog2(`WF_BEAT_BYTES)) && arburst == 2'd1 &&
                    arcache == 4'd3 &&
                    (arlen == 8'(`WF_DQM_BEATS - 1) || arlen == 8'(`WF_MB_BEATS - 1)))
        else begin
            $error("AR attribute fields out of range");
            assert_errors++;
        end

    // Only the DQM request may rise while a FIFO is full
    no_mb_ar_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !arvalid && any_full |=> !arvalid || arlen == 8'(`WF_DQM_BEATS - 1))
        else begin
            $error("Macroblock AR raised while a FIFO was full");
            assert_errors++;
        end

    reload_pulse: assert property (@(posedge clk) disable iff (!rst_n) reload |=> !reload)
        else begin
            $error("reload longer than one cycle");
            assert_errors++;
        end

    fifo_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n) fifo_wr |=> !fifo_wr)
        else begin
            $error("fifo_wr longer than one cycle");
            assert_errors++;
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done_pulse |=> !done_pulse)
        else begin
            $error("done_pulse longer than one cycle");
            assert_errors++;
        end

endmodule

bind webp_fetch_top webp_fetch_properties i_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .arvalid      (arvalid),
    .arready      (arready),
    .arid         (arid),
    .araddr       (araddr),
    .arlen        (arlen),
    .arsize       (arsize),
    .arburst      (arburst),
    .arcache      (arcache),
    .y0_fifo_full (y0_fifo_full),
    .y1_fifo_full (y1_fifo_full),
    .uv_fifo_full (uv_fifo_full),
    .reload       (reload),
    .fifo_wr      (fifo_wr),
    .done_pulse   (done_pulse)
);

// File: bench/webp_fetch_tb.sv
// Testbench of the WebP fetch stage
// AXI memory slave, random FIFO full levels, data checks on reload, fifo_wr and done
`timescale 1ns/100ps
`include "webp_fetch_defines.svh"

module webp_fetch_tb;

    localparam int FRAME_TIMEOUT = 5000;

    logic clk = 1'b0;
    logic rst_n;
    logic [`WF_CTX_WIDTH-1:0] snap_context;
    logic start_pulse;
    logic [`WF_ADDR_WIDTH-1:0] source_address;
    logic [`WF_ADDR_WIDTH-1:0] dqm_address;
    logic [`WF_DIM_WIDTH-1:0] mb_w;
    logic [`WF_DIM_WIDTH-1:0] mb_h;
    logic [`WF_ID_WIDTH-1:0] arid;
    logic [`WF_ADDR_WIDTH-1:0] araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic [`WF_USER_WIDTH-1:0] aruser;
    logic [3:0] arcache;
    logic [1:0] arlock;
    logic [2:0] arprot;
    logic [3:0] arqos;
    logic [3:0] arregion;
    logic arvalid;
    logic arready = 1'b0;
    logic [`WF_ID_WIDTH-1:0] rid = '0;
    logic [`WF_DATA_WIDTH-1:0] rdata = '0;
    logic [1:0] rresp = 2'b00;
    logic rlast = 1'b0;
    logic rvalid = 1'b0;
    logic rready;
    logic [`WF_SCALAR_WIDTH-1:0] lambda_i16;
    logic [`WF_SCALAR_WIDTH-1:0] lambda_i4;
    logic [`WF_SCALAR_WIDTH-1:0] lambda_uv;
    logic [`WF_SCALAR_WIDTH-1:0] tlambda;
    logic [`WF_SCALAR_WIDTH-1:0] lambda_mode;
    logic [`WF_SCALAR_WIDTH-1:0] min_disto;
    logic [`WF_SCALAR_WIDTH-1:0] max_edge;
    logic [`WF_COEF_WIDTH-1:0] y1_q;
    logic [`WF_COEF_WIDTH-1:0] y1_iq;
    logic [`WF_COEF_WIDTH-1:0] y1_sharpen;
    logic [`WF_COEF_WIDTH-1:0] y2_q;
    logic [`WF_COEF_WIDTH-1:0] y2_iq;
    logic [`WF_COEF_WIDTH-1:0] y2_sharpen;
    logic [`WF_COEF_WIDTH-1:0] uv_q;
    logic [`WF_COEF_WIDTH-1:0] uv_iq;
    logic [`WF_COEF_WIDTH-1:0] uv_sharpen;
    logic reload;
    logic y0_fifo_full = 1'b0;
    logic y1_fifo_full = 1'b0;
    logic uv_fifo_full = 1'b0;
    logic [`WF_DATA_WIDTH-1:0] y0_fifo_din;
    logic [`WF_DATA_WIDTH-1:0] y1_fifo_din;
    logic [`WF_DATA_WIDTH-1:0] uv_fifo_din;
    logic fifo_wr;
    logic done_pulse;
    logic rd_error;

    // Memory and slave state
    logic [`WF_DATA_WIDTH-1:0] mem [0:255];
    logic inject_slverr = 1'b0;
    logic slverr_sent = 1'b0;
    logic burst_busy = 1'b0;
    logic [`WF_ADDR_WIDTH-1:0] burst_addr = '0;
    logic [7:0] burst_len = '0;
    logic [7:0] burst_beat = '0;
    logic [`WF_ID_WIDTH-1:0] burst_id = '0;

    // Scoreboard state
    string test_name = "reset";
    int mismatches = 0;
    int timeouts = 0;
    int ar_count = 0;
    int wr_count = 0;
    int done_count = 0;
    int cycle_cnt = 0;
    int last_rlast_cycle = 0;
    logic exp_rd_error = 1'b0;

    webp_fetch_top i_dut (.*);

    always #2 clk = ~clk;

    // Random contents mixed with the full address of each word
    function automatic logic [`WF_DATA_WIDTH-1:0] mem_read(input logic [63:0] addr);
        return mem[addr[12:5]] ^ {4{addr}};
    endfunction

    task automatic check_value(input string what, input logic [255:0] expected,
                               input logic [255:0] actual);
        assert (expected == actual) else begin
            $display("Mismatch %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_params(input logic [63:0] base);
        logic [`WF_DATA_WIDTH-1:0] w [0:5];
        for (int i = 0; i < 6; i++) begin
            w[i] = mem_read(base + 64'(i * `WF_BEAT_BYTES));
        end
        check_value("lambda_i16", w[0][31:0], lambda_i16);
        check_value("lambda_i4", w[0][63:32], lambda_i4);
        check_value("lambda_uv", w[0][95:64], lambda_uv);
        check_value("tlambda", w[0][127:96], tlambda);
        check_value("lambda_mode", w[0][159:128], lambda_mode);
        check_value("min_disto", w[0][191:160], min_disto);
        check_value("max_edge", w[0][223:192], max_edge);
        check_value("y1_q", w[1][127:0], y1_q);
        check_value("y1_iq", w[1][255:128], y1_iq);
        check_value("y2_q", w[2][127:0], y2_q);
        check_value("y2_iq", w[2][255:128], y2_iq);
        check_value("uv_q", w[3][127:0], uv_q);
        check_value("uv_iq", w[3][255:128], uv_iq);
        check_value("y1_sharpen", w[4][127:0], y1_sharpen);
        check_value("y2_sharpen", w[4][255:128], y2_sharpen);
        check_value("uv_sharpen", w[5][127:0], uv_sharpen);
    endtask

    // ------------------------------------------------------------------------
    // AXI read slave with one burst at a time
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        logic bad_beat;
        bad_beat = inject_slverr && !slverr_sent && burst_beat == 8'd1 &&
                   burst_len == 8'(`WF_MB_BEATS - 1);
        if (!rst_n) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            burst_busy <= 1'b0;
        end else begin
            if (start_pulse) begin
                slverr_sent <= 1'b0;
            end
            if (arvalid && arready) begin
                arready    <= 1'b0;
                burst_busy <= 1'b1;
                burst_addr <= araddr;
                burst_len  <= arlen;
                burst_beat <= 8'd0;
                burst_id   <= arid;
            end else if (arvalid && !arready && !burst_busy && $urandom_range(0, 3) == 0) begin
                arready <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid     <= 1'b0;
                burst_beat <= burst_beat + 8'd1;
                if (rlast) begin
                    burst_busy <= 1'b0;
                end
            end else if (burst_busy && !rvalid && $urandom_range(0, 2) != 0) begin
                rvalid <= 1'b1;
                rdata  <= mem_read(burst_addr + 64'(burst_beat) * `WF_BEAT_BYTES);
                rlast  <= (burst_beat == burst_len);
                rid    <= burst_id;
                rresp  <= bad_beat ? 2'b10 : 2'b00;
                if (bad_beat) begin
                    slverr_sent <= 1'b1;
                end
            end
        end
    end

    // FIFO models hold their full levels at random
    always @(posedge clk) begin
        if (!rst_n) begin
            y0_fifo_full <= 1'b0;
            y1_fifo_full <= 1'b0;
            uv_fifo_full <= 1'b0;
        end else begin
            y0_fifo_full <= ($urandom_range(0, 4) == 0);
            y1_fifo_full <= ($urandom_range(0, 4) == 0);
            uv_fifo_full <= ($urandom_range(0, 4) == 0);
        end
    end

    // ------------------------------------------------------------------------
    // Monitor of AR, reload, fifo_wr, done and rd_error
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        logic [63:0] exp_addr;
        logic [63:0] base;
        int total;
        total = int'(mb_w * mb_h);
        if (rst_n) begin
            check_value("rd_error", exp_rd_error, rd_error);
            // rready only inside an open burst
            check_value("rready", burst_busy, rready);
            if (start_pulse) begin
                ar_count     = 0;
                wr_count     = 0;
                done_count   = 0;
                exp_rd_error = 1'b0;
            end
            if (arvalid && arready) begin
                if (ar_count > total) begin
                    $display("Unexpected AR burst after the last macroblock in %s", test_name);
                    mismatches++;
                end
                exp_addr = (ar_count == 0) ? dqm_address :
                           source_address + 64'(ar_count - 1) * `WF_MB_BYTES;
                check_value("araddr", exp_addr, araddr);
                check_value("arlen", (ar_count == 0) ? `WF_DQM_BEATS - 1 : `WF_MB_BEATS - 1,
                            arlen);
                check_value("arid", ar_count % 4, arid);
                check_value("aruser", snap_context[`WF_USER_WIDTH-1:0], aruser);
                check_value("arlock", 0, arlock);
                check_value("arprot", 0, arprot);
                check_value("arqos", 0, arqos);
                check_value("arregion", 0, arregion);
                ar_count++;
            end
            if (rvalid && rready) begin
                if (rresp != 2'b00) begin
                    exp_rd_error = 1'b1;
                end
                if (rlast) begin
                    last_rlast_cycle = cycle_cnt;
                end
            end
            if (reload) begin
                check_params(dqm_address);
            end
            if (fifo_wr) begin
                if (wr_count >= total) begin
                    $display("Extra fifo_wr after the last macroblock in %s", test_name);
                    mismatches++;
                end
                base = source_address + 64'(wr_count) * `WF_MB_BYTES;
                check_value("y0_fifo_din", mem_read(base), y0_fifo_din);
                check_value("y1_fifo_din", mem_read(base + `WF_BEAT_BYTES), y1_fifo_din);
                check_value("uv_fifo_din", mem_read(base + 2 * `WF_BEAT_BYTES), uv_fifo_din);
                wr_count++;
            end
            if (done_pulse) begin
                if (done_count != 0) begin
                    $display("Second done_pulse in %s", test_name);
                    mismatches++;
                end
                check_value("fifo_wr count at done", total, wr_count);
                check_value("AR count at done", total + 1, ar_count);
                check_value("done delay after rlast", last_rlast_cycle + 1, cycle_cnt);
                done_count++;
            end
        end
        cycle_cnt++;
    end

    task automatic run_frame(input string name, input logic [63:0] src,
                             input logic [63:0] dqm, input int w, input int h,
                             input logic inject);
        int cycles;
        test_name = name;
        source_address <= src;
        dqm_address    <= dqm;
        mb_w           <= w;
        mb_h           <= h;
        inject_slverr  <= inject;
        start_pulse    <= 1'b1;
        @(posedge clk);
        start_pulse <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!done_pulse && cycles < FRAME_TIMEOUT);
        if (!done_pulse) begin
            $display("Timeout: no done_pulse within %0d cycles in %s", FRAME_TIMEOUT, name);
            timeouts++;
        end
    endtask

    initial begin
        void'($urandom(1));
        for (int i = 0; i < 256; i++) begin
            for (int j = 0; j < 8; j++) begin
                mem[i][j*32 +: 32] = $urandom;
            end
        end
        rst_n          <= 1'b0;
        start_pulse    <= 1'b0;
        snap_context   <= 32'h0000_00a5;
        source_address <= '0;
        dqm_address    <= '0;
        mb_w           <= 32'd1;
        mb_h           <= 32'd1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        run_frame("frame_3x2", 64'h2000, 64'h1000, 3, 2, 1'b0);
        run_frame("frame_1x1", 64'h4400, 64'h1c00, 1, 1, 1'b0);
        run_frame("frame_3x2_slverr", 64'h2000, 64'h1000, 3, 2, 1'b1);
        check_value("rd_error after SLVERR", 1, rd_error);
        run_frame("frame_1x1_recover", 64'h4400, 64'h1c00, 1, 1, 1'b0);
        check_value("rd_error after restart", 0, rd_error);

        $display("Checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, i_dut.i_properties.assert_errors);
        if (mismatches == 0 && timeouts == 0 && i_dut.i_properties.assert_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: webp_fetch_top.f
+incdir+common
common/webp_fetch_pkg.sv
rtl/axi_master_rd.sv
rtl/dqm_unpack.sv
rtl/mb_addr_gen.sv
rtl/yuv_beat_pack.sv
rtl/webp_fetch_top.sv
bench/webp_fetch_properties.sv
bench/webp_fetch_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module webp_fetch_tb \
		-f webp_fetch_top.f --Mdir obj_dir -o webp_fetch_sim

run: compile
	./obj_dir/webp_fetch_sim +verilator+error+limit+1000 | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
